// File: vlog.f
rtl/labrun_pkg.sv
rtl/main_addr_decode.sv
rtl/main_ctrl_regs.sv
rtl/main_read_mux.sv
rtl/snd_mixer.sv
rtl/labrun_main.sv
tb/tb_labrun_main.sv

// File: run.sh
#!/bin/sh
# compile and run the labrun main board testbench with Verilator
verilator --binary --timing --assert -f vlog.f --top-module tb_labrun_main \
    && ./obj_dir/Vtb_labrun_main 2>&1 | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/tb_labrun_main.sv
// labrun main board testbench
module tb_labrun_main;

    localparam logic [7:0] G_FM0  = 8'd16;
    localparam logic [7:0] G_FM1  = 8'd24;
    localparam logic [7:0] G_PSG0 = 8'd40;
    localparam logic [7:0] G_PSG1 = 8'd12;
    // cycles per test sequence
    localparam int N_DECODE = 400;
    localparam int N_BANK   = 200;
    localparam int N_READ   = 300;
    localparam int N_IRQ    = 300;
    localparam int N_SND    = 200;
    localparam int LIMIT    = 2 * (12 + N_DECODE + N_BANK + N_READ + N_IRQ + N_SND);

    logic clk = 1'b0;
    logic rst, cpu_rnw, cpu_cen, irq_ack, irq_n, rom_cs, ram_cs, pal_cs, gfx_cs;
    logic gfx_irqn, fm0_cs, fm1_cs, prot_cs, service, dip_pause, cen3;
    labrun_pkg::cpu_addr_u cpu_addr;
    logic [labrun_pkg::DATA_W-1:0] cpu_dout, cpu_din, rom_data, ram_dout, pal_dout, gfx_dout;
    logic [labrun_pkg::DATA_W-1:0] fm0_dout, fm1_dout, prot_dout;
    logic [labrun_pkg::ROM_AW-1:0] rom_addr;
    logic [labrun_pkg::GFX_AW-1:0] gfx_addr;
    logic [1:0] start_button, coin_input;
    logic [5:0] joystick1, joystick2;
    logic signed [15:0] fm0_snd, fm1_snd;
    logic signed [9:0] psg0_snd, psg1_snd;
    logic signed [labrun_pkg::SND_W-1:0] snd;

    // reference model state
    logic [labrun_pkg::BANK_W-1:0] m_bank;
    logic m_irq_n, m_irqn_d, m_gfx_cs;
    logic [labrun_pkg::GFX_AW-1:0] m_gfx_addr;
    logic [labrun_pkg::DATA_W-1:0] m_din, m_cab, m_fm;
    logic signed [labrun_pkg::SND_W-1:0] m_snd;
    // expected decode of the address on the bus
    logic e_rom, e_ram, e_pal, e_gfx, e_cfg, e_fm0, e_fm1, e_cab, e_sys, e_bwe, e_prot;
    logic [labrun_pkg::ROM_AW-1:0] e_rom_addr;
    int cycles = 0;
    int seed;

    labrun_main #(.GAIN0(G_FM0), .GAIN1(G_FM1), .GAIN2(G_PSG0), .GAIN3(G_PSG1)) UUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: the test sequences did not finish within %0d cycles", LIMIT);
            abort_run();
        end
    end

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [labrun_pkg::DATA_W-1:0] got,
                              input logic [labrun_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // ROM and graphics addresses share one width
    task automatic check_addr(input string name, input logic [labrun_pkg::ROM_AW-1:0] got,
                              input logic [labrun_pkg::ROM_AW-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_snd(input string name, input logic signed [labrun_pkg::SND_W-1:0] got,
                             input logic signed [labrun_pkg::SND_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // outputs loaded on the last rising edge
    task automatic compare_registered();
        check_byte("cpu_din", cpu_din, m_din);
        check_bit("irq_n", irq_n, m_irq_n);
        check_bit("gfx_cs", gfx_cs, m_gfx_cs);
        check_addr("gfx_addr", {3'b000, gfx_addr}, {3'b000, m_gfx_addr});
        check_snd("snd", snd, m_snd);
    endtask

    // biased towards the small regions of the memory map
    function automatic logic [15:0] pick_addr();
        case ($urandom_range(5))
            0: return {4'h0, 1'b1, 11'($urandom)};
            1: return {8'h00, 8'($urandom)};
            2: return {5'b00000, 11'($urandom)};
            3: return {3'b000, 13'($urandom)};
            4: return {3'b001, 13'($urandom)};
            default: return 16'($urandom);
        endcase
    endfunction

    // full scale on either side now and then
    function automatic int pick_sample(input int bits);
        case ($urandom_range(3))
            0: return (1 << (bits - 1)) - 1;
            1: return -(1 << (bits - 1));
            default: return int'($urandom);
        endcase
    endfunction

    function automatic logic [7:0] cab_byte(input logic start, input logic [5:0] joy);
        return {start, 1'b1, joy[5], joy[4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    task automatic decode_model();
        logic [15:0] a;
        logic io;
        logic [labrun_pkg::BANK_W-1:0] page;
        a = cpu_addr;
        io = (a[15:12] == 4'h0) && a[11];
        e_rom = (a >= 16'h4000) && cpu_rnw;
        e_ram = (a >= 16'h1800) && (a <= 16'h1FFF);
        e_pal = (a >= 16'h1000) && (a <= 16'h17FF);
        e_gfx = (a >= 16'h2000) && (a <= 16'h3FFF);
        e_cfg = a <= 16'h00FF;
        e_fm0 = io && (a[10:8] == labrun_pkg::IO_FM0);
        e_fm1 = io && (a[10:8] == labrun_pkg::IO_FM1);
        e_cab = io && (a[10:8] == labrun_pkg::IO_CAB) && cpu_rnw;
        e_sys = io && (a[10:8] == labrun_pkg::IO_SYS) && cpu_rnw;
        e_bwe = io && (a[10:8] == labrun_pkg::IO_BANK) && !cpu_rnw;
        e_prot = io && (a[10:8] == labrun_pkg::IO_PROT);
        page = m_bank + 3'd2;
        e_rom_addr = a[15] ? {2'b00, a[14:0]} : {page, a[13:0]};
    endtask

    // advance the model by one rising edge
    task automatic model_clock();
        logic [15:0] a;
        int s;
        a = cpu_addr;
        casez ({e_rom, e_ram, m_gfx_cs, e_cab, e_fm0 || e_fm1, e_sys, e_pal, e_prot})
            8'b1???????: m_din = rom_data;
            8'b01??????: m_din = ram_dout;
            8'b001?????: m_din = gfx_dout;
            8'b0001????: m_din = m_cab;
            8'b00001???: m_din = m_fm;
            8'b000001??: m_din = {5'b11111, service, coin_input[1], coin_input[0]};
            8'b0000001?: m_din = pal_dout;
            8'b00000001: m_din = prot_dout;
            default: m_din = 8'hFF;
        endcase
        m_fm = e_fm0 ? fm0_dout : fm1_dout;
        // address bit 0 set reads player 1
        m_cab = a[0] ? cab_byte(start_button[0], joystick1)
                     : cab_byte(start_button[1], joystick2);
        m_gfx_cs = e_gfx || e_cfg;
        m_gfx_addr = {e_gfx, e_gfx && !a[12], a[11:0]};
        if (cpu_cen && e_bwe) begin
            m_bank = cpu_dout[labrun_pkg::BANK_W-1:0];
        end
        if (irq_ack) begin
            m_irq_n = 1'b1;
        end else if (m_irqn_d && !gfx_irqn && dip_pause) begin
            m_irq_n = 1'b0;
        end
        m_irqn_d = gfx_irqn;
        if (cen3) begin
            s = ((int'(fm0_snd) * int'(G_FM0)) >>> 4) + ((int'(fm1_snd) * int'(G_FM1)) >>> 4)
              + ((int'(psg0_snd) * int'(G_PSG0)) >>> 4)
              + ((int'(psg1_snd) * int'(G_PSG1)) >>> 4);
            if (s > 32767) begin
                s = 32767;
            end else if (s < -32768) begin
                s = -32768;
            end
            m_snd = 16'(s);
        end
    endtask

    // one bus cycle from falling edge to falling edge
    task automatic step(input int phase, input int n);
        @(negedge clk);
        compare_registered();
        rom_data = 8'($urandom);
        ram_dout = 8'($urandom);
        pal_dout = 8'($urandom);
        gfx_dout = 8'($urandom);
        fm0_dout = 8'($urandom);
        fm1_dout = 8'($urandom);
        prot_dout = 8'($urandom);
        cpu_dout = 8'($urandom);
        start_button = 2'($urandom);
        coin_input = 2'($urandom);
        joystick1 = 6'($urandom);
        joystick2 = 6'($urandom);
        service = 1'($urandom);
        cpu_cen = 1'($urandom);
        cpu_rnw = 1'($urandom);
        cpu_addr = pick_addr();
        cen3 = 1'b0;
        irq_ack = 1'b0;
        gfx_irqn = 1'b1;
        case (phase)
            2: begin
                // bank write, then a read in the banked or fixed ROM
                if (n % 2 == 0) begin
                    cpu_addr = {4'h0, 1'b1, labrun_pkg::IO_BANK, 8'($urandom)};
                    cpu_rnw = 1'b0;
                end else begin
                    cpu_addr = (n % 4 == 1) ? {2'b01, 14'($urandom)} : {1'b1, 15'($urandom)};
                    cpu_rnw = 1'b1;
                end
                cpu_cen = 1'b1;
            end
            3: begin
                cpu_rnw = 1'b1;
            end
            4: begin
                if ($urandom_range(7) == 0) begin
                    dip_pause = !dip_pause;
                end
                gfx_irqn = 1'($urandom);
                // acknowledge only a pending interrupt and never next to a new edge
                irq_ack = !m_irq_n && ($urandom_range(2) == 0);
                if (irq_ack) begin
                    gfx_irqn = 1'b1;
                end
            end
            5: begin
                cen3 = 1'($urandom);
                fm0_snd = 16'(pick_sample(16));
                fm1_snd = 16'(pick_sample(16));
                psg0_snd = 10'(pick_sample(10));
                psg1_snd = 10'(pick_sample(10));
            end
            default: ;
        endcase
        #1;
        decode_model();
        check_bit("rom_cs", rom_cs, e_rom);
        check_bit("ram_cs", ram_cs, e_ram);
        check_bit("pal_cs", pal_cs, e_pal);
        check_bit("fm0_cs", fm0_cs, e_fm0);
        check_bit("fm1_cs", fm1_cs, e_fm1);
        check_bit("prot_cs", prot_cs, e_prot);
        check_addr("rom_addr", rom_addr, e_rom_addr);
        model_clock();
    endtask

    initial begin
        seed = $urandom(32'h20d34c20);
        rst = 1'b1;
        cpu_addr = 16'h8000;
        cpu_rnw = 1'b1;
        cpu_dout = '0;
        cpu_cen = 1'b0;
        irq_ack = 1'b0;
        rom_data = '0;
        ram_dout = '0;
        pal_dout = '0;
        gfx_dout = '0;
        fm0_dout = '0;
        fm1_dout = '0;
        prot_dout = '0;
        gfx_irqn = 1'b1;
        dip_pause = 1'b1;
        start_button = '0;
        coin_input = '0;
        joystick1 = '0;
        joystick2 = '0;
        service = 1'b0;
        cen3 = 1'b0;
        fm0_snd = '0;
        fm1_snd = '0;
        psg0_snd = '0;
        psg1_snd = '0;
        m_bank = '0;
        m_irq_n = 1'b1;
        m_irqn_d = 1'b1;
        m_snd = '0;
        // inputs stay idle through reset, so the pipeline settles on them
        repeat (2) begin
            decode_model();
            model_clock();
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < N_DECODE; n++) begin
            step(1, n);
        end
        for (int n = 0; n < N_BANK; n++) begin
            step(2, n);
        end
        for (int n = 0; n < N_READ; n++) begin
            step(3, n);
        end
        for (int n = 0; n < N_IRQ; n++) begin
            step(4, n);
        end
        for (int n = 0; n < N_SND; n++) begin
            step(5, n);
        end
        @(negedge clk);
        compare_registered();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: rtl/labrun_main.sv
// labrun main board glue
module labrun_main #(
    parameter logic [7:0] GAIN0 = 8'd16,
    parameter logic [7:0] GAIN1 = 8'd16,
    parameter logic [7:0] GAIN2 = 8'd16,
    parameter logic [7:0] GAIN3 = 8'd16
) (
    input  logic                                   clk,
    input  logic                                   rst,
    // CPU bus
    input  labrun_pkg::cpu_addr_u                  cpu_addr,
    input  logic                                   cpu_rnw,
    input  logic [labrun_pkg::DATA_W-1:0]          cpu_dout,
    input  logic                                   cpu_cen,
    input  logic                                   irq_ack,
    output logic [labrun_pkg::DATA_W-1:0]          cpu_din,
    output logic                                   irq_n,
    // ROM
    output logic [labrun_pkg::ROM_AW-1:0]          rom_addr,
    output logic                                   rom_cs,
    input  logic [labrun_pkg::DATA_W-1:0]          rom_data,
    // work RAM and palette
    output logic                                   ram_cs,
    input  logic [labrun_pkg::DATA_W-1:0]          ram_dout,
    output logic                                   pal_cs,
    input  logic [labrun_pkg::DATA_W-1:0]          pal_dout,
    // graphics chip
    output logic                                   gfx_cs,
    output logic [labrun_pkg::GFX_AW-1:0]          gfx_addr,
    input  logic [labrun_pkg::DATA_W-1:0]          gfx_dout,
    input  logic                                   gfx_irqn,
    // sound chips and protection
    output logic                                   fm0_cs,
    output logic                                   fm1_cs,
    input  logic [labrun_pkg::DATA_W-1:0]          fm0_dout,
    input  logic [labrun_pkg::DATA_W-1:0]          fm1_dout,
    output logic                                   prot_cs,
    input  logic [labrun_pkg::DATA_W-1:0]          prot_dout,
    // cabinet
    input  logic [1:0]                             start_button,
    input  logic [1:0]                             coin_input,
    input  logic [5:0]                             joystick1,
    input  logic [5:0]                             joystick2,
    input  logic                                   service,
    input  logic                                   dip_pause,
    // sound
    input  logic                                   cen3,
    input  logic signed [15:0]                     fm0_snd,
    input  logic signed [15:0]                     fm1_snd,
    input  logic signed [9:0]                      psg0_snd,
    input  logic signed [9:0]                      psg1_snd,
    output logic signed [labrun_pkg::SND_W-1:0]    snd
);

    logic                              pre_gfx;
    logic                              pre_cfg;
    logic                              cab_cs;
    logic                              sys_cs;
    logic                              bank_we;
    logic [labrun_pkg::BANK_W-1:0]     bank;

    main_addr_decode u_decode (
        .cpu_addr (cpu_addr),
        .cpu_rnw  (cpu_rnw),
        .bank     (bank),
        .rom_cs   (rom_cs),
        .ram_cs   (ram_cs),
        .pal_cs   (pal_cs),
        .pre_gfx  (pre_gfx),
        .pre_cfg  (pre_cfg),
        .fm0_cs   (fm0_cs),
        .fm1_cs   (fm1_cs),
        .cab_cs   (cab_cs),
        .sys_cs   (sys_cs),
        .bank_we  (bank_we),
        .prot_cs  (prot_cs),
        .rom_addr (rom_addr)
    );

    main_ctrl_regs u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .bank_we   (bank_we),
        .cpu_dout  (cpu_dout),
        .cpu_addr  (cpu_addr),
        .pre_gfx   (pre_gfx),
        .pre_cfg   (pre_cfg),
        .gfx_irqn  (gfx_irqn),
        .dip_pause (dip_pause),
        .irq_ack   (irq_ack),
        .bank      (bank),
        .irq_n     (irq_n),
        .gfx_cs    (gfx_cs),
        .gfx_addr  (gfx_addr)
    );

    main_read_mux u_mux (
        .clk          (clk),
        .rom_cs       (rom_cs),
        .ram_cs       (ram_cs),
        .gfx_cs       (gfx_cs),
        .cab_cs       (cab_cs),
        .fm0_cs       (fm0_cs),
        .fm1_cs       (fm1_cs),
        .sys_cs       (sys_cs),
        .pal_cs       (pal_cs),
        .prot_cs      (prot_cs),
        .addr0        (cpu_addr.mem.offset[0]),
        .rom_data     (rom_data),
        .ram_dout     (ram_dout),
        .gfx_dout     (gfx_dout),
        .fm0_dout     (fm0_dout),
        .fm1_dout     (fm1_dout),
        .pal_dout     (pal_dout),
        .prot_dout    (prot_dout),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .cpu_din      (cpu_din)
    );

    snd_mixer #(
        .GAIN0 (GAIN0),
        .GAIN1 (GAIN1),
        .GAIN2 (GAIN2),
        .GAIN3 (GAIN3)
    ) u_mixer (
        .clk  (clk),
        .rst  (rst),
        .cen3 (cen3),
        .ch0  (fm0_snd),
        .ch1  (fm1_snd),
        .ch2  (psg0_snd),
        .ch3  (psg1_snd),
        .snd  (snd)
    );

endmodule

// File: rtl/snd_mixer.sv
// four channel sound mixer
module snd_mixer #(
    // 4.4 fixed point, 16 is unity
    parameter logic [7:0] GAIN0 = 8'd16,
    parameter logic [7:0] GAIN1 = 8'd16,
    parameter logic [7:0] GAIN2 = 8'd16,
    parameter logic [7:0] GAIN3 = 8'd16
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   cen3,
    input  logic signed [15:0]                     ch0,
    input  logic signed [15:0]                     ch1,
    input  logic signed [9:0]                      ch2,
    input  logic signed [9:0]                      ch3,
    output logic signed [labrun_pkg::SND_W-1:0]    snd
);

    // 16 bit sample times 9 bit signed gain
    localparam int PROD_W  = 25;
    localparam int SCALE_W = PROD_W - 4;
    // room for four scaled terms
    localparam int SUM_W   = SCALE_W + 2;

    logic signed [15:0]                  ch2_ext;
    logic signed [15:0]                  ch3_ext;
    logic signed [SCALE_W-1:0]           sc0, sc1, sc2, sc3;
    logic signed [SUM_W-1:0]             sum;
    logic                                in_range;
    logic signed [labrun_pkg::SND_W-1:0] sat;

    function automatic logic signed [SCALE_W-1:0] scale(
        input logic signed [15:0] x,
        input logic [7:0]         g
    );
        logic signed [PROD_W-1:0] p;
        p = x * $signed({1'b0, g});
        // drop the fractional gain bits
        return p[PROD_W-1:4];
    endfunction

    assign ch2_ext = {{6{ch2[9]}}, ch2};
    assign ch3_ext = {{6{ch3[9]}}, ch3};

    assign sc0 = scale(ch0, GAIN0);
    assign sc1 = scale(ch1, GAIN1);
    assign sc2 = scale(ch2_ext, GAIN2);
    assign sc3 = scale(ch3_ext, GAIN3);

    assign sum = sc0 + sc1 + sc2 + sc3;

    // fits when all bits above the output sign agree with it
    assign in_range = (&sum[SUM_W-1:labrun_pkg::SND_W-1])
                   || !(|sum[SUM_W-1:labrun_pkg::SND_W-1]);

    always_comb begin
        if (in_range) begin
            sat = sum[labrun_pkg::SND_W-1:0];
        end else if (sum[SUM_W-1]) begin
            sat = {1'b1, {(labrun_pkg::SND_W-1){1'b0}}};
        end else begin
            sat = {1'b0, {(labrun_pkg::SND_W-1){1'b1}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snd <= '0;
        end else if (cen3) begin
            snd <= sat;
        end
    end

endmodule

// File: rtl/main_read_mux.sv
// main CPU read data multiplexer
module main_read_mux (
    input  logic                               clk,
    // chip selects
    input  logic                               rom_cs,
    input  logic                               ram_cs,
    input  logic                               gfx_cs,
    input  logic                               cab_cs,
    input  logic                               fm0_cs,
    input  logic                               fm1_cs,
    input  logic                               sys_cs,
    input  logic                               pal_cs,
    input  logic                               prot_cs,
    // player select for the cabinet port
    input  logic                               addr0,
    // device data
    input  logic [labrun_pkg::DATA_W-1:0]      rom_data,
    input  logic [labrun_pkg::DATA_W-1:0]      ram_dout,
    input  logic [labrun_pkg::DATA_W-1:0]      gfx_dout,
    input  logic [labrun_pkg::DATA_W-1:0]      fm0_dout,
    input  logic [labrun_pkg::DATA_W-1:0]      fm1_dout,
    input  logic [labrun_pkg::DATA_W-1:0]      pal_dout,
    input  logic [labrun_pkg::DATA_W-1:0]      prot_dout,
    // cabinet
    input  logic [1:0]                         start_button,
    input  logic [1:0]                         coin_input,
    input  logic [5:0]                         joystick1,
    input  logic [5:0]                         joystick2,
    input  logic                               service,
    output logic [labrun_pkg::DATA_W-1:0]      cpu_din
);

    logic [labrun_pkg::DATA_W-1:0] cab_byte;
    logic [labrun_pkg::DATA_W-1:0] snd_byte;
    logic [labrun_pkg::DATA_W-1:0] sys_byte;

    // PCB wiring swaps the pairs of direction bits
    function automatic logic [labrun_pkg::DATA_W-1:0] cab_fmt(
        input logic       start,
        input logic [5:0] joy
    );
        return {start, 1'b1, joy[5:4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    // unused bits read high
    assign sys_byte = {5'b11111, service, coin_input};

    // formatted one cycle ahead of cpu_din
    always_ff @(posedge clk) begin
        snd_byte <= fm0_cs ? fm0_dout : fm1_dout;
        if (addr0) begin
            cab_byte <= cab_fmt(start_button[0], joystick1);
        end else begin
            cab_byte <= cab_fmt(start_button[1], joystick2);
        end
    end

    always_ff @(posedge clk) begin
        if (rom_cs) begin
            cpu_din <= rom_data;
        end else if (ram_cs) begin
            cpu_din <= ram_dout;
        end else if (gfx_cs) begin
            cpu_din <= gfx_dout;
        end else if (cab_cs) begin
            cpu_din <= cab_byte;
        end else if (fm0_cs || fm1_cs) begin
            cpu_din <= snd_byte;
        end else if (sys_cs) begin
            cpu_din <= sys_byte;
        end else if (pal_cs) begin
            cpu_din <= pal_dout;
        end else if (prot_cs) begin
            cpu_din <= prot_dout;
        end else begin
            // open bus
            cpu_din <= '1;
        end
    end

endmodule

// File: rtl/main_ctrl_regs.sv
// main board control registers
module main_ctrl_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cpu_cen,
    input  logic                               bank_we,
    input  logic [labrun_pkg::DATA_W-1:0]      cpu_dout,
    input  labrun_pkg::cpu_addr_u              cpu_addr,
    input  logic                               pre_gfx,
    input  logic                               pre_cfg,
    input  logic                               gfx_irqn,
    input  logic                               dip_pause,
    input  logic                               irq_ack,
    output logic [labrun_pkg::BANK_W-1:0]      bank,
    output logic                               irq_n,
    output logic                               gfx_cs,
    output logic [labrun_pkg::GFX_AW-1:0]      gfx_addr
);

    logic gfx_irqn_d;
    logic irq_set;

    // falling edge of the video interrupt, masked by the pause switch
    assign irq_set = gfx_irqn_d && !gfx_irqn && dip_pause;

    // ROM bank, written from the I/O page
    always_ff @(posedge clk) begin
        if (rst) begin
            bank <= '0;
        end else if (cpu_cen && bank_we) begin
            bank <= cpu_dout[labrun_pkg::BANK_W-1:0];
        end
    end

    // interrupt latch, acknowledge wins over a new edge
    always_ff @(posedge clk) begin
        if (rst) begin
            gfx_irqn_d <= 1'b1;
            irq_n      <= 1'b1;
        end else begin
            gfx_irqn_d <= gfx_irqn;
            if (irq_ack) begin
                irq_n <= 1'b1;
            end else if (irq_set) begin
                irq_n <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gfx_cs <= 1'b0;
        end else begin
            gfx_cs <= pre_gfx || pre_cfg;
        end
    end

    // top bit picks tile RAM over config regs
    // next bit is the lower 4 kB of the graphics window
    always_ff @(posedge clk) begin
        gfx_addr <= {pre_gfx,
                     pre_gfx && !cpu_addr.mem.offset[12],
                     cpu_addr.mem.offset[11:0]};
    end

    // CPU only acknowledges an interrupt that is pending or being raised
    irq_ack_pending: assert property (
        @(posedge clk) disable iff (rst)
        irq_ack |-> (!irq_n || irq_set)
    ) else $error("main_ctrl_regs: irq_ack with no interrupt pending");

endmodule

// File: rtl/main_addr_decode.sv
// main CPU address decoder
module main_addr_decode (
    input  labrun_pkg::cpu_addr_u               cpu_addr,
    input  logic                                cpu_rnw,
    input  logic [labrun_pkg::BANK_W-1:0]       bank,
    output logic                                rom_cs,
    output logic                                ram_cs,
    output logic                                pal_cs,
    output logic                                pre_gfx,
    output logic                                pre_cfg,
    output logic                                fm0_cs,
    output logic                                fm1_cs,
    output logic                                cab_cs,
    output logic                                sys_cs,
    output logic                                bank_we,
    output logic                                prot_cs,
    output logic [labrun_pkg::ROM_AW-1:0]       rom_addr
);

    // first banked page sits above the two fixed pages
    localparam logic [labrun_pkg::BANK_W-1:0] BANK_BASE = 2;

    logic                              low_quarter;
    logic                              io_page;
    logic [labrun_pkg::BANK_W-1:0]     bank_page;

    // 0000-3FFF
    assign low_quarter = !cpu_addr.mem.top && !cpu_addr.mem.half;
    // 0800-0FFF
    assign io_page     = (cpu_addr.io.page == 4'd0) && cpu_addr.io.io_en;

    always_comb begin
        // 4000-FFFF, reads only
        rom_cs  = (cpu_addr.mem.top || cpu_addr.mem.half) && cpu_rnw;
        // 1800-1FFF
        ram_cs  = low_quarter && (cpu_addr.mem.offset[13:11] == 3'b011);
        // 1000-17FF
        pal_cs  = low_quarter && (cpu_addr.mem.offset[13:11] == 3'b010);
        // 2000-3FFF
        pre_gfx = low_quarter && cpu_addr.mem.offset[13];
        // 0000-00FF, chip configuration registers
        pre_cfg = low_quarter && (cpu_addr.mem.offset[13:8] == 6'd0);
    end

    always_comb begin
        fm0_cs  = 1'b0;
        fm1_cs  = 1'b0;
        cab_cs  = 1'b0;
        sys_cs  = 1'b0;
        bank_we = 1'b0;
        prot_cs = 1'b0;
        if (io_page) begin
            case (cpu_addr.io.dev)
                labrun_pkg::IO_FM0:  fm0_cs  = 1'b1;
                labrun_pkg::IO_FM1:  fm1_cs  = 1'b1;
                labrun_pkg::IO_CAB:  cab_cs  = cpu_rnw;
                labrun_pkg::IO_SYS:  sys_cs  = cpu_rnw;
                labrun_pkg::IO_BANK: bank_we = !cpu_rnw;
                labrun_pkg::IO_PROT: prot_cs = 1'b1;
                // 6 is the watchdog, not decoded here
                default: ;
            endcase
        end
    end

    assign bank_page = bank + BANK_BASE;

    // fixed upper half, else banked 16 kB window at 4000
    always_comb begin
        if (cpu_addr.mem.top) begin
            rom_addr = {2'b00, cpu_addr.mem.half, cpu_addr.mem.offset};
        end else begin
            rom_addr = {bank_page, cpu_addr.mem.offset};
        end
    end

    // memory regions and I/O devices never overlap on the shared read path
    always_comb begin
        assert final ($onehot0({rom_cs, ram_cs, pal_cs, pre_gfx, pre_cfg, fm0_cs, fm1_cs,
                                cab_cs, sys_cs, bank_we, prot_cs}))
            else $error("main_addr_decode: more than one chip select active");
    end

endmodule

// File: rtl/labrun_pkg.sv
// labrun board definitions
package labrun_pkg;

    // bus and memory widths
    localparam int ADDR_W = 16;
    localparam int ROM_AW = 17;
    localparam int GFX_AW = 14;
    localparam int BANK_W = 3;
    localparam int DATA_W = 8;
    localparam int SND_W  = 16;

    // CPU address, read as memory map or as I/O page
    typedef union packed {
        struct packed {
            // A15, upper 32 kB of fixed ROM
            logic        top;
            // A14
            logic        half;
            logic [13:0] offset;
        } mem;
        struct packed {
            // A15..A12, zero for the I/O page
            logic [3:0]  page;
            // A11
            logic        io_en;
            // A10..A8
            logic [2:0]  dev;
            logic [7:0]  reg_lo;
        } io;
    } cpu_addr_u;

    // device codes in A10..A8 of the I/O page
    localparam logic [2:0] IO_FM0  = 3'd0;
    localparam logic [2:0] IO_FM1  = 3'd1;
    // cabinet inputs, read only
    localparam logic [2:0] IO_CAB  = 3'd2;
    // coins and service, read only
    localparam logic [2:0] IO_SYS  = 3'd3;
    // bank register, write only
    localparam logic [2:0] IO_BANK = 3'd4;
    localparam logic [2:0] IO_PROT = 3'd5;

endpackage
